// File: mipsPkg.sv
// Execute back end shared types
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [5:0]  funcT;
    typedef logic [4:0]  shamtT;

    // SPECIAL function codes ------------------------
    localparam funcT FuncSll   = 6'h00;
    localparam funcT FuncSrl   = 6'h02;
    localparam funcT FuncSra   = 6'h03;
    localparam funcT FuncJr    = 6'h08;
    localparam funcT FuncJalr  = 6'h09;
    localparam funcT FuncMfhi  = 6'h10;
    localparam funcT FuncMthi  = 6'h11;
    localparam funcT FuncMflo  = 6'h12;
    localparam funcT FuncMtlo  = 6'h13;
    localparam funcT FuncMult  = 6'h18;
    localparam funcT FuncMultu = 6'h19;
    localparam funcT FuncAdd   = 6'h20;
    localparam funcT FuncAddu  = 6'h21;
    localparam funcT FuncSub   = 6'h22;
    localparam funcT FuncSubu  = 6'h23;
    localparam funcT FuncAnd   = 6'h24;
    localparam funcT FuncOr    = 6'h25;
    localparam funcT FuncXor   = 6'h26;
    localparam funcT FuncNor   = 6'h27;
    localparam funcT FuncSlt   = 6'h2a;
    localparam funcT FuncSltu  = 6'h2b;

    // SPECIAL2, only meaningful in the multiply class
    localparam funcT FuncClz   = 6'h20;
    localparam funcT FuncClo   = 6'h21;

    typedef enum logic [1:0] {opAlu, opMul, opLoad, opStore} opClassT;
    typedef enum logic {mulIdle, mulBusy} mulStateT;
    typedef enum logic {memIdle, memBus} memStateT;

    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
    } flagsT;

    typedef struct packed {
        opClassT opClass;
        funcT    func;
        shamtT   shamt;
        regAddrT dest;
        wordT    a;
        wordT    b;
        wordT    immediate;
        logic    aluSrc;     // Immediate replaces b
    } issueT;

    typedef struct packed {
        opClassT opClass;
        regAddrT dest;
        wordT    result;     // ALU value or memory address
        wordT    storeData;
        logic    regWrite;
        flagsT   flags;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        regAddrT dest;
        wordT    data;
        flagsT   flags;
    } resultT;

endpackage

// File: alu.sv
// Integer ALU
`timescale 1ns/100ps

module alu (
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    input  mipsPkg::shamtT shamt,
    input  mipsPkg::funcT  func,
    output mipsPkg::wordT  y,
    output mipsPkg::flagsT flags
);

    logic          isSub;
    logic          isAdd;
    mipsPkg::wordT bOp;
    mipsPkg::wordT sum;
    logic          carry;

    // Shared adder, subtract as a + ~b + 1
    assign isSub = (func == mipsPkg::FuncSub) || (func == mipsPkg::FuncSubu);
    assign isAdd = (func == mipsPkg::FuncAdd) || (func == mipsPkg::FuncAddu);
    assign bOp   = isSub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, bOp} + {32'd0, isSub};

    always_comb
    begin
        case (func)
            mipsPkg::FuncAdd,
            mipsPkg::FuncAddu,
            mipsPkg::FuncSub,
            mipsPkg::FuncSubu: y = sum;
            mipsPkg::FuncAnd:  y = a & b;
            mipsPkg::FuncOr:   y = a | b;
            mipsPkg::FuncXor:  y = a ^ b;
            mipsPkg::FuncNor:  y = ~(a | b);
            mipsPkg::FuncSlt:  y = {31'd0, $signed(a) < $signed(b)};
            mipsPkg::FuncSltu: y = {31'd0, a < b};
            mipsPkg::FuncSll:  y = b << shamt;
            mipsPkg::FuncSrl:  y = b >> shamt;
            mipsPkg::FuncSra:  y = $signed(b) >>> shamt;
            default:           y = '0;
        endcase
    end

    // Flags --------------------------------------------
    always_comb
    begin
        flags.c = (isAdd || isSub) ? carry : 1'b0;
        // Signed overflow, trapping forms only
        if ((func == mipsPkg::FuncAdd) || (func == mipsPkg::FuncSub))
            flags.o = (a[31] == bOp[31]) && (sum[31] != a[31]);
        else
            flags.o = 1'b0;
        flags.z = (y == '0);
        flags.n = y[31];
    end

endmodule

// File: mulUnit.sv
// Multiply unit with HI/LO
`timescale 1ns/100ps

module mulUnit (
    input                 Clock,
    input                 rstN,
    input                 start,
    input  mipsPkg::funcT func,
    input  mipsPkg::wordT a,
    input  mipsPkg::wordT b,
    output logic          busy,
    output logic          done,
    output mipsPkg::wordT y
);

    mipsPkg::mulStateT state;
    mipsPkg::wordT     hi;
    mipsPkg::wordT     lo;
    mipsPkg::wordT     mcand;
    logic [63:0]       acc;        // Partial product over multiplier
    logic [4:0]        step;
    logic              negQ;       // Product sign for MULT
    logic [32:0]       sumHi;
    logic [63:0]       nextAcc;
    logic [63:0]       prod;
    logic              isSigned;

    function automatic logic [5:0] leadCount(mipsPkg::wordT v, logic bitVal);
        logic [5:0] cnt;
        logic       stop;
        cnt  = '0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!stop && (v[i] == bitVal))
                cnt = cnt + 6'd1;
            else
                stop = 1'b1;
        end
        return cnt;
    endfunction

    assign isSigned = (func == mipsPkg::FuncMult);
    assign busy     = (state == mipsPkg::mulBusy);

    // One shift-add step
    always_comb
    begin
        sumHi   = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
        nextAcc = {sumHi, acc[31:1]};
        prod    = negQ ? (~nextAcc + 64'd1) : nextAcc;
    end

    always_ff @(posedge Clock)
    begin
        if (!rstN)
        begin
            state <= mipsPkg::mulIdle;
            step  <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == mipsPkg::mulIdle)
            begin
                if (start && ((func == mipsPkg::FuncMult) || (func == mipsPkg::FuncMultu)))
                begin
                    state <= mipsPkg::mulBusy;
                    step  <= '0;
                end
            end
            else
            begin
                step <= step + 5'd1;
                if (step == 5'd31)
                begin
                    state <= mipsPkg::mulIdle;
                    done  <= 1'b1;
                end
            end
        end
    end

    // Datapath and HI/LO ----------------------------
    always_ff @(posedge Clock)
    begin
        if (busy)
        begin
            acc <= nextAcc;
            if (step == 5'd31)
                {hi, lo} <= prod;
        end
        else if (start)
        begin
            // Operands enter as magnitudes, sign restored at the end
            mcand <= (isSigned && a[31]) ? (~a + 32'd1) : a;
            acc   <= {32'd0, (isSigned && b[31]) ? (~b + 32'd1) : b};
            negQ  <= isSigned && (a[31] ^ b[31]);
            if (func == mipsPkg::FuncMthi)
                hi <= a;
            if (func == mipsPkg::FuncMtlo)
                lo <= a;
        end
    end

    always_comb
    begin
        case (func)
            mipsPkg::FuncMfhi: y = hi;
            mipsPkg::FuncMflo: y = lo;
            mipsPkg::FuncClz:  y = {26'd0, leadCount(a, 1'b0)};
            mipsPkg::FuncClo:  y = {26'd0, leadCount(a, 1'b1)};
            default:           y = '0;
        endcase
    end

    startWhileBusy: assert property (@(posedge Clock) disable iff (!rstN)
        start |-> !busy);

endmodule

// File: exStage.sv
// Execute stage
`timescale 1ns/100ps

module exStage (
    input                   Clock,
    input                   rstN,
    input  mipsPkg::issueT  issue,
    input                   issueValid,
    output logic            issueReady,
    output mipsPkg::exMemT  exOut,
    output logic            exValid,
    input                   exReady
);

    mipsPkg::wordT  bSel;
    mipsPkg::wordT  aluY;
    mipsPkg::flagsT aluFlags;
    mipsPkg::wordT  mulY;
    logic           mulBusy;
    logic           mulDone;
    logic           started;    // Holds off issue for a cycle after reset
    logic           accept;
    logic           isMulLong;
    mipsPkg::exMemT nextItem;

    assign bSel      = issue.aluSrc ? issue.immediate : issue.b;
    assign accept    = issueValid && issueReady;
    assign isMulLong = (issue.opClass == mipsPkg::opMul) &&
                       ((issue.func == mipsPkg::FuncMult) || (issue.func == mipsPkg::FuncMultu));

    assign issueReady = started && !mulBusy && !mulDone && (!exValid || exReady);

    alu alu0 (
        .a     (issue.a),
        .b     (bSel),
        .shamt (issue.shamt),
        .func  (issue.func),
        .y     (aluY),
        .flags (aluFlags)
    );

    mulUnit mul0 (
        .Clock (Clock),
        .rstN  (rstN),
        .start (accept && (issue.opClass == mipsPkg::opMul)),
        .func  (issue.func),
        .a     (issue.a),
        .b     (bSel),
        .busy  (mulBusy),
        .done  (mulDone),
        .y     (mulY)
    );

    // Route by op class ------------------------------
    always_comb
    begin
        nextItem.opClass   = issue.opClass;
        nextItem.dest      = issue.dest;
        nextItem.storeData = issue.b;
        nextItem.result    = '0;
        nextItem.regWrite  = 1'b0;
        nextItem.flags     = '0;
        case (issue.opClass)
            mipsPkg::opAlu:
                if ((issue.func != mipsPkg::FuncJr) && (issue.func != mipsPkg::FuncJalr))
                begin
                    nextItem.result   = aluY;
                    nextItem.regWrite = 1'b1;
                    nextItem.flags    = aluFlags;
                end
            mipsPkg::opMul:
            begin
                nextItem.result   = mulY;
                nextItem.regWrite = !isMulLong && (issue.func != mipsPkg::FuncMthi) &&
                                    (issue.func != mipsPkg::FuncMtlo);
                nextItem.flags.z  = (mulY == '0);
                nextItem.flags.n  = mulY[31];
            end
            default:
                nextItem.result = issue.a + issue.immediate;   // Load/store address
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (!rstN)
        begin
            exValid <= 1'b0;
            started <= 1'b0;
        end
        else
        begin
            started <= 1'b1;
            if (accept)
                exValid <= !isMulLong;     // Multiply waits for done
            else if (mulDone)
                exValid <= 1'b1;
            else if (exReady)
                exValid <= 1'b0;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (accept)
            exOut <= nextItem;
    end

    holdWhileStalled: assert property (@(posedge Clock) disable iff (!rstN)
        (exValid && !exReady) |=> (exValid && $stable(exOut)));

endmodule

// File: memStage.sv
// Memory stage with Wishbone master
`timescale 1ns/100ps

module memStage (
    input                   Clock,
    input                   rstN,
    input  mipsPkg::exMemT  exIn,
    input                   exValid,
    output logic            exReady,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output logic [29:0]     wbAdr,
    output mipsPkg::wordT   wbDatW,
    input  mipsPkg::wordT   wbDatR,
    input                   wbAck,
    output mipsPkg::resultT result,
    output logic            resultValid
);

    mipsPkg::memStateT state;
    mipsPkg::exMemT    pend;       // Memory op held for the bus cycle
    logic              isMem;

    assign exReady = (state == mipsPkg::memIdle);
    assign isMem   = (exIn.opClass == mipsPkg::opLoad) || (exIn.opClass == mipsPkg::opStore);

    // Bus signals come straight from the held item
    assign wbWe   = (pend.opClass == mipsPkg::opStore);
    assign wbAdr  = pend.result[31:2];
    assign wbDatW = pend.storeData;

    always_ff @(posedge Clock)
    begin
        if (!rstN)
        begin
            state       <= mipsPkg::memIdle;
            wbCyc       <= 1'b0;
            wbStb       <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            resultValid <= 1'b0;
            if (state == mipsPkg::memIdle)
            begin
                if (exValid && isMem)
                begin
                    state <= mipsPkg::memBus;
                    wbCyc <= 1'b1;
                    wbStb <= 1'b1;
                end
                else if (exValid)
                    resultValid <= 1'b1;
            end
            else if (wbAck)
            begin
                state       <= mipsPkg::memIdle;
                wbCyc       <= 1'b0;
                wbStb       <= 1'b0;
                resultValid <= 1'b1;
            end
        end
    end

    // Result beat ------------------------------------
    always_ff @(posedge Clock)
    begin
        if ((state == mipsPkg::memIdle) && exValid)
        begin
            pend            <= exIn;
            result.regWrite <= exIn.regWrite;
            result.dest     <= exIn.dest;
            result.data     <= exIn.result;
            result.flags    <= exIn.flags;
        end
        else if ((state == mipsPkg::memBus) && wbAck)
        begin
            result.regWrite <= !wbWe;
            result.dest     <= pend.dest;
            result.data     <= wbWe ? '0 : wbDatR;
            result.flags    <= '{c: 1'b0, z: !wbWe && (wbDatR == '0), o: 1'b0,
                                 n: !wbWe && wbDatR[31]};
        end
    end

    // Slave may only ack an open strobe
    ackInsideCycle: assert property (@(posedge Clock) disable iff (!rstN)
        wbAck |-> (wbCyc && wbStb));

endmodule

// File: dataRam.sv
// Wishbone data RAM
`timescale 1ns/100ps

module dataRam #(
    parameter int RamWords = 256
) (
    input                 Clock,
    input                 rstN,
    input                 wbCyc,
    input                 wbStb,
    input                 wbWe,
    input        [29:0]   wbAdr,
    input  mipsPkg::wordT wbDatW,
    output mipsPkg::wordT wbDatR,
    output logic          wbAck
);

    localparam int IdxW = $clog2(RamWords);

    mipsPkg::wordT   mem [RamWords];
    logic [IdxW-1:0] idx;
    logic            req;

    assign idx = wbAdr[IdxW-1:0];      // Upper address bits ignored
    assign req = wbCyc && wbStb && !wbAck;

    always_ff @(posedge Clock)
    begin
        if (!rstN)
            wbAck <= 1'b0;
        else
            wbAck <= req;              // Single-cycle ack
    end

    always_ff @(posedge Clock)
    begin
        if (req && wbWe)
            mem[idx] <= wbDatW;
        wbDatR <= mem[idx];
    end

endmodule

// File: execCore.sv
// Execute back end top level
`timescale 1ns/100ps

module execCore #(
    parameter int RamWords = 256
) (
    input                   Clock,
    input                   rstN,
    input  mipsPkg::issueT  issue,
    input                   issueValid,
    output logic            issueReady,
    output mipsPkg::resultT result,
    output logic            resultValid
);

    mipsPkg::exMemT exOut;
    logic           exValid;
    logic           exReady;

    // Wishbone between memory stage and RAM
    logic           wbCyc;
    logic           wbStb;
    logic           wbWe;
    logic [29:0]    wbAdr;
    mipsPkg::wordT  wbDatW;
    mipsPkg::wordT  wbDatR;
    logic           wbAck;

    exStage ex0 (
        .Clock      (Clock),
        .rstN       (rstN),
        .issue      (issue),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .exOut      (exOut),
        .exValid    (exValid),
        .exReady    (exReady)
    );

    memStage mem0 (
        .Clock       (Clock),
        .rstN        (rstN),
        .exIn        (exOut),
        .exValid     (exValid),
        .exReady     (exReady),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatW      (wbDatW),
        .wbDatR      (wbDatR),
        .wbAck       (wbAck),
        .result      (result),
        .resultValid (resultValid)
    );

    dataRam #(
        .RamWords (RamWords)
    ) ram0 (
        .Clock  (Clock),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

endmodule

// File: tbClock.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tbClock #(
    parameter int HalfPeriod  = 50,     // 100 ns period
    parameter int ResetCycles = 3
) (
    output logic Clock,
    output logic rstN
);

    initial
    begin
        Clock = 1'b0;
        forever #HalfPeriod Clock = ~Clock;
    end

    // Release on a falling edge, clear of the sampling edge
    initial
    begin
        rstN = 1'b0;
        repeat (ResetCycles) @(negedge Clock);
        rstN = 1'b1;
    end

endmodule

// File: tbExec.sv
// Execute back end testbench
`timescale 1ns/100ps

module tbExec;

    localparam int RamWords      = 256;
    localparam int NumOps        = 400;
    localparam int TimeoutCycles = 40 * NumOps;

    localparam mipsPkg::funcT AluFuncs [15] = '{
        mipsPkg::FuncAdd, mipsPkg::FuncAddu, mipsPkg::FuncSub, mipsPkg::FuncSubu,
        mipsPkg::FuncAnd, mipsPkg::FuncOr, mipsPkg::FuncXor, mipsPkg::FuncNor,
        mipsPkg::FuncSlt, mipsPkg::FuncSltu, mipsPkg::FuncSll, mipsPkg::FuncSrl,
        mipsPkg::FuncSra, mipsPkg::FuncJr, mipsPkg::FuncJalr
    };

    logic            Clock;
    logic            rstN;
    mipsPkg::issueT  issue;
    logic            issueValid;
    logic            issueReady;
    mipsPkg::resultT result;
    logic            resultValid;

    // Reference model state
    mipsPkg::resultT expQ[$];          // Expected beats in issue order
    mipsPkg::wordT   modelHi;
    mipsPkg::wordT   modelLo;
    mipsPkg::wordT   modelRam [RamWords];
    logic            written [RamWords];
    int              writtenList[$];

    int   cycleCount = 0;
    int   beats      = 0;
    logic mulPending = 1'b0;
    int   lowCount   = 0;              // Stall cycles seen after a multiply

    tbClock clk0 (
        .Clock (Clock),
        .rstN  (rstN)
    );

    execCore #(
        .RamWords (RamWords)
    ) dut0 (
        .Clock       (Clock),
        .rstN        (rstN),
        .issue       (issue),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .result      (result),
        .resultValid (resultValid)
    );

    // Reporting --------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected)
            failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    // Reference model --------------------------------
    function automatic logic [5:0] countLeading(input mipsPkg::wordT v);
        int k;
        k = 0;
        while ((k < 32) && !v[31 - k])
            k++;
        return 6'(k);
    endfunction

    function automatic mipsPkg::resultT aluExpect(input mipsPkg::issueT op);
        mipsPkg::resultT r;
        mipsPkg::wordT   bv;
        mipsPkg::wordT   y;
        logic [32:0]     wide;
        r          = '0;
        y          = '0;
        bv         = op.aluSrc ? op.immediate : op.b;
        r.dest     = op.dest;
        r.regWrite = 1'b1;
        case (op.func)
            mipsPkg::FuncAdd, mipsPkg::FuncAddu:
            begin
                wide      = {1'b0, op.a} + {1'b0, bv};
                y         = wide[31:0];
                r.flags.c = wide[32];
                r.flags.o = (op.func == mipsPkg::FuncAdd) && (op.a[31] == bv[31]) &&
                            (y[31] != op.a[31]);
            end
            mipsPkg::FuncSub, mipsPkg::FuncSubu:
            begin
                y         = op.a - bv;
                r.flags.c = (op.a >= bv);      // No borrow
                r.flags.o = (op.func == mipsPkg::FuncSub) && (op.a[31] != bv[31]) &&
                            (y[31] != op.a[31]);
            end
            mipsPkg::FuncAnd:  y = op.a & bv;
            mipsPkg::FuncOr:   y = op.a | bv;
            mipsPkg::FuncXor:  y = op.a ^ bv;
            mipsPkg::FuncNor:  y = ~(op.a | bv);
            mipsPkg::FuncSlt:  y = {31'd0, (op.a ^ 32'h8000_0000) < (bv ^ 32'h8000_0000)};
            mipsPkg::FuncSltu: y = {31'd0, op.a < bv};
            mipsPkg::FuncSll:  y = bv << op.shamt;
            mipsPkg::FuncSrl:  y = bv >> op.shamt;
            mipsPkg::FuncSra:  y = (bv >> op.shamt) | (bv[31] ? ~(32'hffff_ffff >> op.shamt) : 32'd0);
            default:           r.regWrite = 1'b0;     // JR and JALR
        endcase
        if (r.regWrite)
        begin
            r.data    = y;
            r.flags.z = (y == '0);
            r.flags.n = y[31];
        end
        return r;
    endfunction

    task automatic predictMul(input mipsPkg::issueT op, output mipsPkg::resultT r);
        mipsPkg::wordT bv;
        r      = '0;
        r.dest = op.dest;
        bv     = op.aluSrc ? op.immediate : op.b;
        case (op.func)
            mipsPkg::FuncMult:
                {modelHi, modelLo} = {{32{op.a[31]}}, op.a} * {{32{bv[31]}}, bv};
            mipsPkg::FuncMultu:
                {modelHi, modelLo} = {32'd0, op.a} * {32'd0, bv};
            mipsPkg::FuncMthi: modelHi = op.a;
            mipsPkg::FuncMtlo: modelLo = op.a;
            mipsPkg::FuncMfhi: {r.regWrite, r.data} = {1'b1, modelHi};
            mipsPkg::FuncMflo: {r.regWrite, r.data} = {1'b1, modelLo};
            mipsPkg::FuncClz:  {r.regWrite, r.data} = {1'b1, 26'd0, countLeading(op.a)};
            mipsPkg::FuncClo:  {r.regWrite, r.data} = {1'b1, 26'd0, countLeading(~op.a)};
            default: ;
        endcase
        // Ops without a register write still report a zero result
        r.flags.z = (r.data == '0);
        r.flags.n = r.data[31];
    endtask

    task automatic predict(input mipsPkg::issueT op, output mipsPkg::resultT r);
        mipsPkg::wordT addr;
        int            idx;
        r    = '0;
        addr = op.a + op.immediate;
        idx  = int'(addr >> 2) % RamWords;
        case (op.opClass)
            mipsPkg::opAlu: r = aluExpect(op);
            mipsPkg::opMul: predictMul(op, r);
            mipsPkg::opStore:
            begin
                r.dest        = op.dest;
                modelRam[idx] = op.b;
            end
            default:
            begin
                r.dest     = op.dest;
                r.regWrite = 1'b1;
                r.data     = modelRam[idx];
                r.flags.z  = (r.data == '0);
                r.flags.n  = r.data[31];
            end
        endcase
    endtask

    // Stimulus ---------------------------------------
    function automatic mipsPkg::wordT pickValue();
        case ($urandom % 8)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    task automatic makeAluOp(inout mipsPkg::issueT op);
        int sel;
        sel          = $urandom % 15;
        op.opClass   = mipsPkg::opAlu;
        op.func      = AluFuncs[sel];
        op.a         = pickValue();
        op.b         = pickValue();
        op.immediate = pickValue();
        op.aluSrc    = ($urandom % 4) == 0;
        if (($urandom % 8) == 0)
            op.b = op.a;                   // Equal operands for zero results
    endtask

    task automatic makeMemOp(inout mipsPkg::issueT op, input logic wantStore);
        logic          doStore;
        int            idx;
        int            pick;
        mipsPkg::wordT addr;
        doStore = wantStore || (writtenList.size() == 0);   // Loads only from stored words
        if (doStore)
            idx = $urandom % RamWords;
        else
        begin
            pick = $urandom % writtenList.size();
            idx  = writtenList[pick];
        end
        addr         = 32'(idx) << 2;
        op.opClass   = doStore ? mipsPkg::opStore : mipsPkg::opLoad;
        op.immediate = $urandom & 32'h0000_00fc;
        op.a         = addr - op.immediate;
        op.b         = pickValue();
        op.aluSrc    = ($urandom % 2) == 1;
        if (doStore && !written[idx])
        begin
            written[idx] = 1'b1;
            writtenList.push_back(idx);
        end
    endtask

    task automatic makeOp(input int n, output mipsPkg::issueT op);
        mipsPkg::wordT rnd;
        rnd      = $urandom;
        op       = '0;
        op.dest  = rnd[4:0];
        op.shamt = rnd[9:5];
        if (n < 120)
            makeAluOp(op);
        else if (n < 171)
        begin
            // Multiply, then read HI and LO
            op.opClass = mipsPkg::opMul;
            op.a       = pickValue();
            op.b       = pickValue();
            case ((n - 120) % 3)
                0:       op.func = rnd[10] ? mipsPkg::FuncMult : mipsPkg::FuncMultu;
                1:       op.func = mipsPkg::FuncMfhi;
                default: op.func = mipsPkg::FuncMflo;
            endcase
        end
        else if (n < 231)
        begin
            op.opClass = mipsPkg::opMul;
            op.a       = pickValue();
            if (rnd[11])
                op.a = op.a >> rnd[16:12];
            if (rnd[17])
                op.a = ~op.a;
            case ((n - 171) % 6)
                0:       op.func = mipsPkg::FuncMthi;
                1:       op.func = mipsPkg::FuncMfhi;
                2:       op.func = mipsPkg::FuncMtlo;
                3:       op.func = mipsPkg::FuncMflo;
                4:       op.func = mipsPkg::FuncClz;
                default: op.func = mipsPkg::FuncClo;
            endcase
        end
        else if (n < 331)
            makeMemOp(op, (n < 247) || rnd[18]);   // Seed the RAM with stores first
        else if (rnd[20])
            makeAluOp(op);
        else
            makeMemOp(op, rnd[21]);
    endtask

    // Checking ---------------------------------------
    task automatic checkResult();
        mipsPkg::resultT want;
        if (resultValid)
        begin
            if (expQ.size() == 0)
                failRun("A result beat arrived with no instruction outstanding");
            else
            begin
                want = expQ.pop_front();
                checkVal("result.regWrite", {31'd0, result.regWrite}, {31'd0, want.regWrite});
                checkVal("result.dest", {27'd0, result.dest}, {27'd0, want.dest});
                checkVal("result.data", result.data, want.data);
                checkVal("result.flags", {28'd0, result.flags}, {28'd0, want.flags});
                beats++;
            end
        end
    endtask

    task automatic watchMulStall();
        if (mulPending)
        begin
            if (!issueReady)
                lowCount++;
            else
            begin
                checkVal("issueReady low during multiply", 32'(lowCount >= 32), 32'd1);
                mulPending = 1'b0;
            end
        end
    endtask

    always @(posedge Clock)
    begin
        cycleCount++;
        if (cycleCount > TimeoutCycles)
            failRun($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                              cycleCount, beats, NumOps));
    end

    initial
    begin
        mipsPkg::issueT  op;
        mipsPkg::resultT want;
        int              n;
        void'($urandom(32'h227f154f));
        issue      = '0;
        issueValid = 1'b0;
        modelHi    = '0;
        modelLo    = '0;
        foreach (written[i])
            written[i] = 1'b0;
        n = 0;
        wait (rstN);
        while (n < NumOps)
        begin
            @(negedge Clock);
            checkResult();
            watchMulStall();
            // Ready only changes on a rising edge, so an op driven now is taken
            if (issueReady)
            begin
                makeOp(n, op);
                predict(op, want);
                expQ.push_back(want);
                if ((op.opClass == mipsPkg::opMul) &&
                    ((op.func == mipsPkg::FuncMult) || (op.func == mipsPkg::FuncMultu)))
                begin
                    mulPending = 1'b1;
                    lowCount   = 0;
                end
                issue      = op;
                issueValid = 1'b1;
                n++;
            end
            else
                issueValid = 1'b0;
        end
        // Drain what is still in flight
        while (expQ.size() != 0)
        begin
            @(negedge Clock);
            issueValid = 1'b0;
            checkResult();
            watchMulStall();
        end
        repeat (4)
        begin
            @(negedge Clock);
            checkResult();
        end
        if (beats == NumOps)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
            failRun($sformatf("Saw %0d result beats for %0d instructions", beats, NumOps));
    end

endmodule

// File: sim.f
mipsPkg.sv
alu.sv
mulUnit.sv
exStage.sv
memStage.sv
dataRam.sv
execCore.sv
tbClock.sv
tbExec.sv

// File: run.sh
#!/bin/sh
# Build and run the execute back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps \
        -f sim.f --top-module tbExec -Mdir obj_dir -o simExec; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simExec)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
